// File: vga_pkg.sv
package vga_pkg;

	// 640x480 at 60 Hz, clk is the pixel clock
	localparam int h_active = 640;
	localparam int h_front = 16;
	localparam int h_sync = 96;
	localparam int h_back = 48;
	localparam int h_total = h_active + h_front + h_sync + h_back; // 800

	localparam int v_active = 480; // lines
	localparam int v_front = 10;
	localparam int v_sync = 2;
	localparam int v_back = 33;
	localparam int v_total = v_active + v_front + v_sync + v_back; // 525

	localparam int coord_w = 11; // enough for 0..799

	typedef struct packed {
		logic [coord_w-1:0] x; // column, 0..h_total-1
		logic [coord_w-1:0] y; // line, 0..v_total-1
		logic active; // inside the visible 640x480
	} pixel_t;

	typedef struct packed {
		logic hsync; // active low
		logic vsync; // active low
	} sync_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

// File: tile_pkg.sv
package tile_pkg;

	typedef enum logic [2:0] {
		free = 3'd0, // nothing to stand on
		regular = 3'd1,
		gate = 3'd2,
		death = 3'd3,
		wall = 3'd4 // only beyond the grid edges
	} tile_e;

	localparam int tile_shift = 6; // 64 px tiles
	localparam int num_rows = 7;
	localparam int num_cols = 10;
	localparam int gate_row = 4; // tile opened by gate_open
	localparam int gate_col = 6;

	// playfield at reset, row 0 on top
	localparam tile_e [0:num_rows-1][0:num_cols-1] init_map = '{
		'{free, free, free, free, free, free, free, free, free, free},
		'{regular, free, free, free, regular, free, free, free, free, free},
		'{free, free, regular, free, free, free, free, free, free, free},
		'{free, regular, free, regular, free, regular, free, regular, free, regular},
		'{free, free, free, free, free, free, regular, free, free, free},
		'{regular, free, free, free, free, free, free, free, regular, free},
		'{free, regular, regular, regular, gate, regular, free, regular, free, regular}
	};

	typedef struct packed {
		logic in_grid; // pixel on one of the 7x10 tiles
		tile_e step_type; // tile under the pixel
		logic [vga_pkg::coord_w-1:0] tile_x; // top-left corner of that tile
		logic [vga_pkg::coord_w-1:0] tile_y;
		tile_e left;
		tile_e up;
		tile_e right;
		tile_e down;
	} tile_report_t;

endpackage

// File: vga_sync.sv
`timescale 1ns/1ps

module vga_sync (
	input logic clk,
	input logic rst_n,
	output vga_pkg::pixel_t pix,
	output vga_pkg::sync_t sync
);
	import vga_pkg::*;

	localparam int hs_start = h_active + h_front; // 656
	localparam int hs_end = hs_start + h_sync; // first x past the pulse (752)
	localparam int vs_start = v_active + v_front; // 490
	localparam int vs_end = vs_start + v_sync; // 492

	logic [coord_w-1:0] x_q;
	logic [coord_w-1:0] y_q;
	logic x_wrap;
	logic y_wrap;

	assign x_wrap = (x_q == coord_w'(h_total - 1)); // last pixel of the line
	assign y_wrap = (y_q == coord_w'(v_total - 1)); // last line of the frame

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_q <= '0;
			y_q <= '0;
		end else begin
			if (x_wrap) begin
				x_q <= '0;
				if (y_wrap) begin
					y_q <= '0; // new frame
				end else begin
					y_q <= y_q + 1'b1;
				end
			end else begin
				x_q <= x_q + 1'b1;
			end
		end
	end

	// pixel and sync decoded straight from the counters
	assign pix.x = x_q;
	assign pix.y = y_q;
	assign pix.active = (x_q < coord_w'(h_active)) && (y_q < coord_w'(v_active));

	assign sync.hsync = !((x_q >= coord_w'(hs_start)) && (x_q < coord_w'(hs_end)));
	assign sync.vsync = !((y_q >= coord_w'(vs_start)) && (y_q < coord_w'(vs_end)));

	// x counter must wrap before h_total
	a_x_range: assert property (@(posedge clk) disable iff (!rst_n)
		x_q < coord_w'(h_total))
		else $error("vga_sync: x counter reached h_total");

endmodule

// File: tile_map.sv
`timescale 1ns/1ps

module tile_map (
	input logic clk,
	input logic rst_n,
	input vga_pkg::pixel_t pix,
	input logic gate_open,
	output tile_pkg::tile_report_t report
);
	import vga_pkg::*;
	import tile_pkg::*;

	tile_e [0:num_rows-1][0:num_cols-1] map_q; // live playfield
	logic [coord_w-1:0] col; // tile index under the pixel
	logic [coord_w-1:0] row;
	logic in_grid;
	tile_report_t report_d;
	logic wall_seen;

	assign col = pix.x >> tile_shift;
	assign row = pix.y >> tile_shift;
	// rows 448..479 fall on row 7, below the grid
	assign in_grid = pix.active && (col < coord_w'(num_cols)) && (row < coord_w'(num_rows));

	// map storage, gate stays open until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			map_q <= init_map;
		end else if (gate_open) begin
			map_q[gate_row][gate_col] <= gate;
		end
	end

	always_comb begin
		report_d = '0; // free everywhere, zero corners
		if (in_grid) begin
			report_d.in_grid = 1'b1;
			report_d.step_type = map_q[row][col];
			report_d.tile_x = col << tile_shift; // index times 64
			report_d.tile_y = row << tile_shift;

			// side edges are walls
			if (col == '0) begin
				report_d.left = wall;
			end else begin
				report_d.left = map_q[row][col - 1'b1];
			end
			if (col == coord_w'(num_cols - 1)) begin
				report_d.right = wall;
			end else begin
				report_d.right = map_q[row][col + 1'b1];
			end

			// ceiling is wall, floor is a fall to death
			if (row == '0) begin
				report_d.up = wall;
			end else begin
				report_d.up = map_q[row - 1'b1][col];
			end
			if (row == coord_w'(num_rows - 1)) begin
				report_d.down = death;
			end else begin
				report_d.down = map_q[row + 1'b1][col];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			report <= '0; // not in grid
		end else begin
			report <= report_d; // one cycle behind pix
		end
	end

	// scan the stored map for edge-only types
	always_comb begin
		wall_seen = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			for (int c = 0; c < num_cols; c++) begin
				if (map_q[r][c] == wall) begin
					wall_seen = 1'b1;
				end
			end
		end
	end

	// wall is a neighbour rule only, never a stored tile
	a_no_wall_in_map: assert property (@(posedge clk) disable iff (!rst_n)
		!wall_seen)
		else $error("tile_map: wall stored in the map");

endmodule

// File: delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter type payload_t = logic,
	parameter int depth = 1,
	parameter payload_t reset_value = '0 // e.g. '1 keeps sync inactive
) (
	input logic clk,
	input logic rst_n,
	input payload_t d,
	output payload_t q
);

	payload_t stage_q [depth]; // stage 0 takes d

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				stage_q[i] <= reset_value;
			end
		end else begin
			stage_q[0] <= d;
			for (int i = 1; i < depth; i++) begin
				stage_q[i] <= stage_q[i-1]; // shift one stage per clock
			end
		end
	end

	assign q = stage_q[depth-1];

	a_depth: assert property (@(posedge clk) depth >= 1)
		else $error("delay_line: depth below 1");

endmodule

// File: tile_renderer.sv
`timescale 1ns/1ps

module tile_renderer (
	input logic clk,
	input logic rst_n,
	input vga_pkg::pixel_t pix,
	input tile_pkg::tile_report_t report,
	output vga_pkg::rgb_t rgb
);
	import vga_pkg::*;
	import tile_pkg::*;

	rgb_t base; // full colour of the tile type
	rgb_t shaded; // half intensity for the border
	logic border;

	always_comb begin
		case (report.step_type)
			regular: base = '{r: 4'h8, g: 4'h8, b: 4'h8}; // grey
			gate: base = '{r: 4'h0, g: 4'hC, b: 4'h0}; // green
			death: base = '{r: 4'hC, g: 4'h0, b: 4'h0}; // red
			wall: base = '{r: 4'hF, g: 4'hF, b: 4'hF}; // white
			default: base = '{r: 4'h0, g: 4'h0, b: 4'h4}; // background blue
		endcase
	end

	assign shaded = '{r: base.r >> 1, g: base.g >> 1, b: base.b >> 1};
	// first column and first line of every tile
	assign border = (pix.x[tile_shift-1:0] == '0) || (pix.y[tile_shift-1:0] == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
		end else if (!pix.active) begin
			rgb <= '0; // blanking stays black
		end else if (!report.in_grid || (report.step_type == free)) begin
			rgb <= '{r: 4'h0, g: 4'h0, b: 4'h4}; // dark blue sky
		end else if (border) begin
			rgb <= shaded;
		end else begin
			rgb <= base;
		end
	end

endmodule

// File: tile_game_top.sv
`timescale 1ns/1ps

module tile_game_top (
	input logic clk,
	input logic rst_n,
	input logic gate_open, // single-cycle strobe from game logic
	output tile_pkg::tile_report_t tile_report, // 1 cycle after pix
	output vga_pkg::rgb_t rgb, // 2 cycles after pix
	output vga_pkg::sync_t sync // aligned with rgb
);
	import vga_pkg::*;

	pixel_t pix; // scan position, cycle 0
	pixel_t pix_d1; // lined up with tile_report
	sync_t sync_raw;

	vga_sync u_vga_sync (
		.clk(clk),
		.rst_n(rst_n),
		.pix(pix),
		.sync(sync_raw)
	);

	tile_map u_tile_map (
		.clk(clk),
		.rst_n(rst_n),
		.pix(pix),
		.gate_open(gate_open),
		.report(tile_report)
	);

	delay_line #(.payload_t(pixel_t), .depth(1)) u_pix_delay (
		.clk(clk),
		.rst_n(rst_n),
		.d(pix),
		.q(pix_d1)
	);

	tile_renderer u_tile_renderer (
		.clk(clk),
		.rst_n(rst_n),
		.pix(pix_d1),
		.report(tile_report),
		.rgb(rgb)
	);

	// map stage plus render stage, sync idles high
	delay_line #(.payload_t(sync_t), .depth(2), .reset_value('1)) u_sync_delay (
		.clk(clk),
		.rst_n(rst_n),
		.d(sync_raw),
		.q(sync)
	);

endmodule

// File: tb_tile_game_top.sv
`timescale 1ns/1ps

module tb_tile_game_top;
	import vga_pkg::*;
	import tile_pkg::*;

	localparam int clk_period = 100;
	localparam int drive_delay = 10; // inputs move after the rising edge
	localparam int frame_cycles = 800 * 525; // 420000 pixels per frame
	localparam int test_frames = 4; // lookup, gate+render, edges, sync each end a frame later
	localparam int watchdog_cycles = test_frames * frame_cycles + 20000;

	logic clk;
	logic rst_n;
	logic gate_open;
	tile_report_t tile_report;
	rgb_t rgb;
	sync_t sync;

	int scan_pos; // pixel the DUT scans right now
	int errors;
	int checks;
	int unsigned lcg_state;
	tile_e ref_map [0:num_rows-1][0:num_cols-1];
	// layout at reset, row 0 on top: . free, R regular, G gate
	string layout [0:num_rows-1] = '{"..........", "R...R.....", "..R.......",
		".R.R.R.R.R", "......R...", "R.......R.", ".RRRGR.R.R"};

	tile_game_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.gate_open(gate_open),
		.tile_report(tile_report),
		.rgb(rgb),
		.sync(sync)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_pos <= 0;
		end else if (scan_pos == frame_cycles - 1) begin
			scan_pos <= 0; // next frame
		end else begin
			scan_pos <= scan_pos + 1;
		end
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // upper bits, better spread
	endfunction

	function automatic tile_e tile_at(int row, int col);
		if (row < 0 || col < 0 || col >= num_cols) begin
			return wall; // ceiling and side edges
		end
		if (row >= num_rows) begin
			return death; // fall below the bottom row
		end
		return ref_map[row][col];
	endfunction

	function automatic tile_report_t expected_report(int x, int y);
		tile_report_t rep;
		rep = '0; // outside the grid
		if (x < 640 && y < 448) begin
			rep.in_grid = 1'b1;
			rep.step_type = tile_at(y / 64, x / 64);
			rep.tile_x = 11'((x / 64) * 64);
			rep.tile_y = 11'((y / 64) * 64);
			rep.left = tile_at(y / 64, x / 64 - 1);
			rep.up = tile_at(y / 64 - 1, x / 64);
			rep.right = tile_at(y / 64, x / 64 + 1);
			rep.down = tile_at(y / 64 + 1, x / 64);
		end
		return rep;
	endfunction

	function automatic rgb_t expected_rgb(int x, int y);
		tile_report_t rep;
		rgb_t c;
		rep = expected_report(x, y);
		if (x >= 640 || y >= 480) begin
			return 12'h000; // blanking
		end
		if (!rep.in_grid || rep.step_type == free) begin
			return 12'h004; // sky
		end
		case (rep.step_type)
			regular: c = 12'h888;
			gate: c = 12'h0c0;
			death: c = 12'hc00;
			default: c = 12'hfff;
		endcase
		if (x % 64 == 0 || y % 64 == 0) begin
			c = {c.r >> 1, c.g >> 1, c.b >> 1}; // tile border
		end
		return c;
	endfunction

	task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
				name, actual, expected, $time);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#(drive_delay);
	endtask

	task automatic wait_scan(int x, int y, int lag);
		while (scan_pos != (y * 800 + x + lag) % frame_cycles) begin
			next_cycle();
		end
	endtask

	task automatic check_report_at(int x, int y);
		wait_scan(x, y, 1); // report trails pix by one
		check_value($sformatf("tile_report(%0d,%0d)", x, y), tile_report, expected_report(x, y));
	endtask

	task automatic check_rgb_at(int x, int y);
		wait_scan(x, y, 2); // map stage plus render stage
		check_value($sformatf("rgb(%0d,%0d)", x, y), rgb, expected_rgb(x, y));
	endtask

	task automatic reset_test();
		next_cycle();
		check_value("sync in reset", sync, 2'b11);
		check_value("rgb in reset", rgb, 12'h000);
		check_value("tile_report.in_grid in reset", tile_report.in_grid, 1'b0);
		next_cycle();
		rst_n = 1'b1; // 2 cycles held
		#1;
		check_value("sync after reset", sync, 2'b11);
		check_value("rgb after reset", rgb, 12'h000);
		check_value("tile_report.in_grid after reset", tile_report.in_grid, 1'b0);
	endtask

	task automatic lookup_test();
		int x;
		int y;
		for (int i = 0; i < 200; i++) begin
			y = 1 + (i * 446) / 200 + int'(lcg_next() % 2); // rising rows, one scan
			x = int'(lcg_next() % 640);
			check_report_at(x, y);
		end
	endtask

	task automatic gate_test();
		next_cycle();
		gate_open = 1'b1;
		next_cycle();
		gate_open = 1'b0; // single-cycle strobe
		ref_map[4][6] = gate;
		check_report_at(6 * 64 + 5, 4 * 64 + 3);
		check_value("tile_report.step_type at gate", tile_report.step_type, gate);
		check_report_at(6 * 64 + 40, 4 * 64 + 60);
		check_report_at(6 * 64 + 10, 5 * 64 + 2); // tile below sees it
		check_value("tile_report.up below gate", tile_report.up, gate);
	endtask

	task automatic render_test();
		check_rgb_at(64, 384); // regular, border line
		check_rgb_at(10, 400); // free
		check_rgb_at(70, 400);
		check_rgb_at(260, 400); // gate
		check_rgb_at(256, 420); // gate border column
		check_rgb_at(700, 420); // h blanking
		check_rgb_at(300, 460); // below grid
		check_rgb_at(10, 500); // v blanking
	endtask

	task automatic edge_test();
		for (int c = 0; c < 10; c++) begin
			check_report_at(c * 64 + 7, 3);
			check_value("tile_report.up on top row", tile_report.up, wall);
		end
		for (int r = 1; r < 6; r++) begin
			check_report_at(1, r * 64 + 5);
			check_value("tile_report.left in column 0", tile_report.left, wall);
			check_report_at(6 * 64 + 16, r * 64 + 5); // row 4 is the open gate
			check_report_at(600, r * 64 + 5);
			check_value("tile_report.right in column 9", tile_report.right, wall);
		end
		for (int c = 0; c < 10; c++) begin
			check_report_at(c * 64 + 7, 400);
			check_value("tile_report.down on bottom row", tile_report.down, death);
		end
		for (int y = 448; y < 480; y += 15) begin
			check_report_at(320, y);
		end
	endtask

	task automatic sync_test();
		int aligned;
		for (int n = 0; n < frame_cycles; n++) begin
			next_cycle();
			aligned = (scan_pos + frame_cycles - 2) % frame_cycles; // pixel behind sync
			check_value("sync.hsync", sync.hsync,
				!((aligned % 800) >= 656 && (aligned % 800) <= 751));
			check_value("sync.vsync", sync.vsync,
				!((aligned / 800) >= 490 && (aligned / 800) <= 491));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		gate_open = 1'b0;
		errors = 0;
		checks = 0;
		lcg_state = 20;
		for (int r = 0; r < num_rows; r++) begin
			for (int c = 0; c < num_cols; c++) begin
				ref_map[r][c] = (layout[r][c] == "R") ? regular :
					(layout[r][c] == "G") ? gate : free;
			end
		end
		reset_test();
		lookup_test();
		gate_test();
		render_test();
		edge_test();
		sync_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog: tests still running after %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: tile_game_top.f
vga_pkg.sv
tile_pkg.sv
vga_sync.sv
tile_map.sv
delay_line.sv
tile_renderer.sv
tile_game_top.sv
tb_tile_game_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_tile_game_top
FILELIST = tile_game_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

SIM_BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
